// File: design/spi_pkg.sv
package spi_pkg;

    // System clocks per SCLK period, each SCLK level lasts half of it
    localparam int spi_clk_div = 4;

    // Transmit FIFO geometry
    localparam int spi_fifo_depth = 8;
    localparam int spi_fifo_aw = 3;

    // One data byte on the wire, MSB goes out first
    typedef logic [7:0] spi_byte_t;

    // Outgoing SPI pins, chip enable is active high
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic en;
    } spi_pins_t;

    // Received byte with its one-cycle strobe
    typedef struct packed {
        logic      valid;
        spi_byte_t data;
    } spi_rx_t;

endpackage

// File: design/spi_tx_fifo.sv
module spi_tx_fifo import spi_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_valid,
    input  spi_byte_t wr_data,
    input  logic      rd,
    output spi_byte_t rd_data,
    output logic      full,
    output logic      empty
);

    spi_byte_t mem [spi_fifo_depth];

    logic [spi_fifo_aw-1:0] wr_ptr;
    logic [spi_fifo_aw-1:0] rd_ptr;
    logic [spi_fifo_aw:0]   count;
    logic [spi_fifo_aw:0]   count_next;
    logic                   do_wr;
    logic                   do_rd;

    // Writes into a full buffer and reads from an empty one are ignored
    assign do_wr = wr_valid && !full;
    assign do_rd = rd && !empty;

    always_comb begin
        count_next = count;
        case ({do_wr, do_rd})
            2'b10: count_next = count + 1'b1;
            2'b01: count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
        end
    end

    // Flags come from the next occupancy so they line up with count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full  <= 1'b0;
            empty <= 1'b1;
        end else begin
            full  <= (count_next == (spi_fifo_aw + 1)'(spi_fifo_depth));
            empty <= (count_next == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head of the queue, meaningful while empty is low
    assign rd_data = mem[rd_ptr];

endmodule

// File: design/spi_byte_shifter.sv
module spi_byte_shifter import spi_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  spi_byte_t tx_byte,
    input  logic      miso,
    output logic      sclk,
    output logic      mosi,
    output logic      done,
    output spi_rx_t   rx
);

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_active,
        st_finish
    } state_t;

    typedef logic [$clog2(spi_clk_div / 2)-1:0] div_cnt_t;

    state_t    state;
    state_t    state_next;
    div_cnt_t  div_cnt;
    logic [2:0] bit_cnt;
    spi_byte_t tx_reg;
    spi_byte_t rx_reg;
    logic      tick;
    logic      rise;
    logic      fall;

    // Half period boundary of SCLK, only counted while the byte is active
    assign tick = (state == st_active) && (div_cnt == div_cnt_t'(spi_clk_div / 2 - 1));
    assign rise = tick && !sclk;
    assign fall = tick && sclk;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_load;
                end
            end
            st_load: begin
                state_next = st_active;
            end
            st_active: begin
                // Eighth falling edge closes the byte
                if (fall && bit_cnt == 3'd7) begin
                    state_next = st_finish;
                end
            end
            st_finish: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // SCLK divider, idles low outside the active state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            sclk    <= 1'b0;
        end else if (state == st_active) begin
            if (tick) begin
                div_cnt <= '0;
                sclk    <= ~sclk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end else begin
            div_cnt <= '0;
            sclk    <= 1'b0;
        end
    end

    // One count per completed bit, i.e. per falling edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (state == st_load) begin
            bit_cnt <= '0;
        end else if (fall) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // MSB sits on MOSI from the load cycle, next bit after each falling edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_reg <= '0;
        end else if (state == st_idle && start) begin
            tx_reg <= tx_byte;
        end else if (fall) begin
            tx_reg <= {tx_reg[6:0], 1'b0};
        end
    end

    // MISO sampled on rising edges
    always_ff @(posedge clk) begin
        if (rise) begin
            rx_reg <= {rx_reg[6:0], miso};
        end
    end

    // Strobe goes out one clock after the last falling edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= (state == st_finish);
        end
    end

    assign mosi     = tx_reg[7];
    assign rx.valid = done;
    assign rx.data  = rx_reg;

endmodule

// File: design/spi_frame_ctrl.sv
module spi_frame_ctrl import spi_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      empty,
    input  spi_byte_t rd_data,
    input  logic      done,
    output logic      rd,
    output logic      start,
    output spi_byte_t tx_byte,
    output logic      en
);

    typedef enum logic [1:0] {
        st_idle,
        st_pop,
        st_issue,
        st_busy
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (!empty) begin
                    state_next = st_pop;
                end
            end
            st_pop: begin
                state_next = st_issue;
            end
            st_issue: begin
                state_next = st_busy;
            end
            st_busy: begin
                // Keep the frame open while bytes are still queued
                if (done) begin
                    state_next = empty ? st_idle : st_pop;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // Chip enable spans every state except idle, registered for a clean pin
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en <= 1'b0;
        end else begin
            en <= (state_next != st_idle);
        end
    end

    // Head byte captured during the pop
    always_ff @(posedge clk) begin
        if (state == st_pop) begin
            tx_byte <= rd_data;
        end
    end

    assign rd    = (state == st_pop);
    assign start = (state == st_issue);

endmodule

// File: design/spi_master_top.sv
module spi_master_top import spi_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_valid,
    input  spi_byte_t wr_data,
    output logic      full,
    input  logic      miso,
    output spi_pins_t pins,
    output spi_rx_t   rx
);

    spi_byte_t fifo_data;
    spi_byte_t tx_byte;
    logic      fifo_rd;
    logic      fifo_empty;
    logic      start;
    logic      done;
    logic      sclk;
    logic      mosi;
    logic      en;

    // Host side byte queue
    spi_tx_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_valid(wr_valid),
        .wr_data (wr_data),
        .rd      (fifo_rd),
        .rd_data (fifo_data),
        .full    (full),
        .empty   (fifo_empty)
    );

    spi_frame_ctrl u_ctrl (
        .clk    (clk),
        .rst    (rst),
        .empty  (fifo_empty),
        .rd_data(fifo_data),
        .done   (done),
        .rd     (fifo_rd),
        .start  (start),
        .tx_byte(tx_byte),
        .en     (en)
    );

    spi_byte_shifter u_shifter (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .tx_byte(tx_byte),
        .miso   (miso),
        .sclk   (sclk),
        .mosi   (mosi),
        .done   (done),
        .rx     (rx)
    );

    assign pins = '{sclk: sclk, mosi: mosi, en: en};

endmodule

// File: verif/spi_slave_model.sv
module spi_slave_model import spi_pkg::*; (
    input  spi_pins_t pins,
    output logic      miso,
    output int        byte_count,
    output spi_byte_t last_byte
);
    timeunit 1ns;
    timeprecision 1ps;

    spi_byte_t rx_sh   = '0;
    spi_byte_t tx_sh   = '0;
    spi_byte_t got     = '0;
    int        bit_cnt = 0;
    int        count_q = 0;
    logic      sclk_q  = 1'b0;
    logic      en_q    = 1'b0;

    // Mode 0 slave, samples MOSI on rising SCLK and moves MISO after falling SCLK
    always @(pins) begin
        if (pins.en && !en_q) begin
            // Each frame opens with a fixed answer
            bit_cnt = 0;
            tx_sh   = 8'hA5;
        end else if (pins.en && pins.sclk && !sclk_q) begin
            rx_sh   = {rx_sh[6:0], pins.mosi};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                got     = rx_sh;
                count_q = count_q + 1;
            end
        end else if (pins.en && !pins.sclk && sclk_q) begin
            if (bit_cnt == 0) begin
                // Byte boundary, answer the next byte with the inverse of this one
                tx_sh = ~got;
            end else begin
                tx_sh = {tx_sh[6:0], 1'b0};
            end
        end
        sclk_q = pins.sclk;
        en_q   = pins.en;
    end

    assign miso       = tx_sh[7];
    assign byte_count = count_q;
    assign last_byte  = got;

endmodule

// File: verif/tb_spi_master.sv
module tb_spi_master import spi_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic      clk = 1'b0;
    logic      rst;
    logic      wr_valid;
    spi_byte_t wr_data;
    logic      full;
    logic      miso;
    spi_pins_t pins;
    spi_rx_t   rx;
    int        slave_count;
    spi_byte_t slave_byte;

    // Accepted bytes in write order for the MOSI and receive checks
    spi_byte_t exp_mosi[$];
    spi_byte_t rx_src[$];
    int        accepted  = 0;
    int        mosi_seen = 0;
    int        rx_seen   = 0;

    spi_master_top dut0 (.*);
    spi_slave_model slave0 (.pins, .miso, .byte_count(slave_count), .last_byte(slave_byte));

    always #20 clk = ~clk;

    // Slave answer rule seen from the host side
    function automatic spi_rx_t expected_rx(input logic first, input spi_byte_t prev);
        spi_rx_t r;
        r.valid = 1'b1;
        r.data  = first ? 8'hA5 : ~prev;
        return r;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_rx(input string name, input spi_rx_t act, input spi_rx_t exp);
        if (act !== exp) begin
            fail_now($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                               $time, name, act, exp));
        end
    endtask

    task automatic check_mosi(input string name, input spi_byte_t act, input spi_byte_t exp);
        if (act !== exp) begin
            fail_now($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                               $time, name, act, exp));
        end
    endtask

    task automatic check_level(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            fail_now($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
                               $time, name, act, exp));
        end
    endtask

    // Inputs move 5 ns after the rising edge
    task automatic write_byte(input spi_byte_t b, input logic accept);
        @(posedge clk);
        #5;
        wr_valid = 1'b1;
        wr_data  = b;
        if (accept) begin
            exp_mosi.push_back(b);
            rx_src.push_back(b);
            accepted++;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #5;
        wr_valid = 1'b0;
    endtask

    task automatic wait_en(input logic level, input int limit);
        int n;
        n = 0;
        while (pins.en !== level) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                fail_now($sformatf("Timeout waiting for chip enable to go %0b", level));
            end
        end
    endtask

    // Wait until every accepted byte has gone out and come back and the frame has closed
    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (mosi_seen != accepted || rx_seen != accepted || pins.en) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                fail_now("Timeout waiting for the queued bytes to finish");
            end
        end
    endtask

    // Compare process runs on the falling edge where all DUT outputs are settled
    initial begin : compare_proc
        logic      frame_first;
        logic      en_prev;
        spi_byte_t prev_tx;
        frame_first = 1'b1;
        en_prev     = 1'b0;
        prev_tx     = '0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (slave_count != mosi_seen) begin
                    if (exp_mosi.size() == 0) begin
                        fail_now("Slave received a byte that the FIFO should not hold");
                    end else begin
                        check_mosi("mosi byte", slave_byte, exp_mosi.pop_front());
                        mosi_seen++;
                    end
                end
                if (rx.valid) begin
                    if (rx_src.size() == 0) begin
                        fail_now("Receive pulse with no byte in flight");
                    end else begin
                        check_rx("rx", rx, expected_rx(frame_first, prev_tx));
                        prev_tx     = rx_src.pop_front();
                        frame_first = 1'b0;
                        rx_seen++;
                    end
                end
                // Falling chip enable closes the frame
                if (en_prev && !pins.en) begin
                    frame_first = 1'b1;
                end
                en_prev = pins.en;
            end
        end
    end

    initial begin : stimulus
        int   n;
        int   seen;
        int   occ;
        int   gap;
        logic acc;
        void'($urandom(32'haea8e88c));
        rst      = 1'b1;
        wr_valid = 1'b0;
        wr_data  = '0;

        // Outputs quiet through reset and just after it
        for (int i = 0; i < 12; i++) begin
            @(posedge clk);
            #5;
            if (i == 7) begin
                rst = 1'b0;
            end
            check_level("pins.sclk", pins.sclk, 1'b0);
            check_level("pins.mosi", pins.mosi, 1'b0);
            check_level("pins.en", pins.en, 1'b0);
            check_level("rx.valid", rx.valid, 1'b0);
            check_level("full", full, 1'b0);
        end

        // A single byte gives a receive pulse exactly 38 clocks after the write cycle
        write_byte(8'h96, 1'b1);
        for (int i = 1; i <= 38; i++) begin
            idle_cycle();
            check_level("rx.valid", rx.valid, i == 38);
            if (i == 38) begin
                check_level("pins.en", pins.en, 1'b1);
            end
        end
        wait_drained(100);

        // Four bytes back to back form one frame
        write_byte(8'h3C, 1'b1);
        write_byte(8'hC3, 1'b1);
        write_byte(8'h5A, 1'b1);
        write_byte(8'h0F, 1'b1);
        idle_cycle();
        wait_en(1'b1, 10);
        n    = 0;
        seen = 0;
        while (seen < 4) begin
            @(negedge clk);
            n++;
            if (n > 200) begin
                fail_now("Timeout waiting for the burst of four bytes");
            end
            check_level("pins.en", pins.en, 1'b1);
            if (rx.valid) begin
                seen++;
            end
        end
        wait_drained(100);

        // Overrun the FIFO while the lead byte is shifting
        write_byte(spi_byte_t'($urandom), 1'b1);
        idle_cycle();
        wait_en(1'b1, 10);
        // Lead byte is popped on the edge after enable rises
        @(posedge clk);
        occ = 0;
        for (int i = 0; i < 12; i++) begin
            acc = (occ < spi_fifo_depth);
            write_byte(spi_byte_t'($urandom), acc);
            check_level("full", full, occ == spi_fifo_depth);
            if (acc) begin
                occ++;
            end
        end
        idle_cycle();
        check_level("full", full, 1'b1);
        wait_drained(600);

        // Random gaps split the frames wherever the FIFO runs dry
        for (int i = 0; i < 30; i++) begin
            gap = $urandom_range(80, 0);
            repeat (gap) begin
                idle_cycle();
            end
            n = 0;
            while (accepted - slave_count >= spi_fifo_depth) begin
                idle_cycle();
                n++;
                if (n > 400) begin
                    fail_now("Timeout waiting for room in the transmit FIFO");
                end
            end
            write_byte(spi_byte_t'($urandom), 1'b1);
        end
        idle_cycle();
        wait_drained(1500);

        $display("Test passed");
        $finish;
    end

endmodule

// File: files.f
design/spi_pkg.sv
design/spi_tx_fifo.sv
design/spi_byte_shifter.sv
design/spi_frame_ctrl.sv
design/spi_master_top.sv
verif/spi_slave_model.sv
verif/tb_spi_master.sv
